// File: Bender.yml
package:
  name: cnn_core

export_include_dirs:
  - logic

sources:
  # RTL in compile order
  - include_dirs:
      - logic
    files:
      - logic/cnn_pkg.sv
      - logic/shared_sram.sv
      - logic/mem_arbiter.sv
      - logic/cmd_sequencer.sv
      - logic/vector_engine.sv
      - logic/cnn_core_top.sv
  # Testbench
  - target: test
    include_dirs:
      - logic
    files:
      - dv/cnn_core_tb.sv

// File: cnn_core_top.f
+incdir+logic
logic/cnn_pkg.sv
logic/shared_sram.sv
logic/mem_arbiter.sv
logic/cmd_sequencer.sv
logic/vector_engine.sv
logic/cnn_core_top.sv
dv/cnn_core_tb.sv

// File: dv/cnn_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module cnn_core_tb;
    import cnn_pkg::*;

    localparam int    AW           = `CNN_ADDR_W;
    localparam string TRACE_FILE   = "dv/cnn_core_trace.txt";
    localparam int    SCRATCH_ADDR = `CNN_MEM_DEPTH - 16;

    logic          clk;
    logic          rst;
    logic          i_op_en;
    logic [6:0]    i_cmd_count;
    logic          i_host_req;
    logic          i_host_we;
    logic [AW-1:0] i_host_addr;
    logic [31:0]   i_host_wdata;
    wire           o_host_ack;
    wire  [31:0]   o_host_rdata;
    wire           o_busy;
    wire           o_irq;

    // Trace records in file order
    int unsigned load_addr_q[$];
    logic [31:0] load_data_q[$];
    int unsigned exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    // Loaded words that no command overwrites
    int unsigned stable_q[$];
    logic [31:0] shadow [`CNN_MEM_DEPTH];
    bit          is_result [`CNN_MEM_DEPTH];
    int unsigned cmd_total;
    int unsigned record_total;
    int unsigned elem_total;

    // Run monitor state
    bit          running;
    bit          irq_seen;
    logic        host_ack_q;
    int unsigned overlap_reads;

    cnn_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .i_op_en      (i_op_en),
        .i_cmd_count  (i_cmd_count),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_ack   (o_host_ack),
        .o_host_rdata (o_host_rdata),
        .o_busy       (o_busy),
        .o_irq        (o_irq)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Four-phase host access with read data taken while ack is high
    task automatic host_access(input bit we, input int unsigned addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        i_host_we    = we;
        i_host_addr  = AW'(addr);
        i_host_wdata = wdata;
        i_host_req   = 1'b1;
        do @(negedge clk); while (!o_host_ack);
        rdata = o_host_rdata;
        @(posedge clk);
        #1;
        i_host_req = 1'b0;
        // Fields stay put until the ack is gone
        do @(negedge clk); while (o_host_ack);
    endtask

    task automatic read_trace();
        int          fd;
        int          rc;
        string       kind;
        string       rest;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file");
        end
        while (1) begin
            rc = $fscanf(fd, "%s", kind);
            if (rc != 1) begin
                break;
            end
            if (kind.getc(0) == "#") begin
                // Comment runs to the end of the line
                rc = $fgets(rest, fd);
            end else if (kind == "load" || kind == "expect") begin
                rc = $fscanf(fd, "%h %h", addr, data);
                if (rc != 2) begin
                    abort_run({"malformed ", kind, " record in the trace"});
                end
                if (addr >= `CNN_MEM_DEPTH) begin
                    abort_run("trace address lies outside the memory");
                end
                if (kind == "load") begin
                    load_addr_q.push_back(addr);
                    load_data_q.push_back(data);
                    shadow[addr] = data;
                end else begin
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(data);
                    is_result[addr] = 1'b1;
                end
                record_total++;
            end else if (kind == "start") begin
                rc = $fscanf(fd, "%h", data);
                if (rc != 1) begin
                    abort_run("malformed start record in the trace");
                end
                cmd_total = data;
                record_total++;
            end else begin
                abort_run({"unknown record kind in the trace: ", kind});
            end
        end
        $fclose(fd);
        if (cmd_total == 0) begin
            abort_run("trace holds no start record");
        end
    endtask

    // Elements per command from the loaded command words
    // NOPs cost nothing
    task automatic count_elements();
        logic [31:0] word;
        elem_total = 0;
        for (int i = 0; i < cmd_total; i++) begin
            word = shadow[`CNN_CMD_BASE + i * `CNN_CMD_WORDS];
            if (cnn_op_e'(word[2:0]) != NOP) begin
                elem_total += word[31:16];
            end
        end
        foreach (load_addr_q[i]) begin
            if (!is_result[load_addr_q[i]]) begin
                stable_q.push_back(load_addr_q[i]);
            end
        end
    endtask

    task automatic watchdog(input int unsigned cycles);
        repeat (cycles) @(posedge clk);
        $display("run hung waiting for the interrupt after %0d cycles", cycles);
        $display("tests failed");
        $fatal(1);
    endtask

    // Busy must hold until the interrupt
    // Host acks during engine work are counted
    // Once raised the interrupt stays and the engine makes no more accesses
    always @(negedge clk) begin
        if (running && !irq_seen && !o_irq) begin
            check_value("busy until interrupt", 32'd1, {31'd0, o_busy});
            if (o_host_ack && !host_ack_q && dut.eng_req) begin
                overlap_reads++;
            end
        end else if (running) begin
            irq_seen = 1'b1;
            check_value("irq held", 32'd1, {31'd0, o_irq});
            check_value("engine quiet after interrupt", 32'd0,
                        {31'd0, dut.arb_req[ENG]});
        end
        host_ack_q = o_host_ack;
    end

    initial begin
        logic [31:0] rd;
        int unsigned gap;
        int unsigned pick;
        int unsigned addr;
        void'($urandom(32'h4406_9b7f));
        clk           = 1'b0;
        rst           = 1'b1;
        i_op_en       = 1'b0;
        i_cmd_count   = '0;
        i_host_req    = 1'b0;
        i_host_we     = 1'b0;
        i_host_addr   = '0;
        i_host_wdata  = '0;
        running       = 1'b0;
        irq_seen      = 1'b0;
        host_ack_q    = 1'b0;
        overlap_reads = 0;
        read_trace();
        count_elements();
        fork
            watchdog(record_total * 40 + elem_total * 20);
        join_none
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Quiet outputs after reset and a host write with read back
        @(negedge clk);
        check_value("irq after reset", 32'd0, {31'd0, o_irq});
        check_value("busy after reset", 32'd0, {31'd0, o_busy});
        check_value("host ack after reset", 32'd0, {31'd0, o_host_ack});
        host_access(1'b1, SCRATCH_ADDR, 32'h3c5a_96e1, rd);
        host_access(1'b0, SCRATCH_ADDR, 32'd0, rd);
        check_value("host write then read", 32'h3c5a_96e1, rd);

        // Commands, operands and untouched destination words
        foreach (load_addr_q[i]) begin
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
            host_access(1'b1, load_addr_q[i], load_data_q[i], rd);
        end

        // Count held for the whole run
        // Start is a one-cycle pulse
        @(posedge clk);
        #1;
        i_cmd_count = cmd_total[6:0];
        i_op_en     = 1'b1;
        @(posedge clk);
        #1;
        i_op_en = 1'b0;
        running = 1'b1;

        // Host keeps reading operands while the sequencer and engine work
        pick = 0;
        while (!o_irq) begin
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
            addr = stable_q[pick % stable_q.size()];
            host_access(1'b0, addr, 32'd0, rd);
            check_value($sformatf("host read %03h during run", addr), shadow[addr], rd);
            pick++;
        end
        if (overlap_reads == 0) begin
            abort_run("no host read was served while the engine was running");
        end
        check_value("busy after interrupt", 32'd0, {31'd0, o_busy});

        foreach (exp_addr_q[i]) begin
            host_access(1'b0, exp_addr_q[i], 32'd0, rd);
            check_value($sformatf("result %03h", exp_addr_q[i]), exp_data_q[i], rd);
        end

        // Interrupt stays until reset
        repeat (10) begin
            @(negedge clk);
            check_value("irq held", 32'd1, {31'd0, o_irq});
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/cnn_core_trace.txt
# load <addr> <data> preloads a word, start <count> runs the command list
# expect <addr> <data> is checked after the interrupt, all numbers hex
# Commands of four words: count and opcode, operand A, operand B, result base
# ADD_RELU x5, MAX2 x4, NOP x4, AVG2 x5, COPY x4
load 000 00050001  load 001 00000040  load 002 00000050  load 003 00000100
load 004 00040002  load 005 00000040  load 006 00000050  load 007 00000110
load 008 00040000  load 009 00000040  load 00a 00000050  load 00b 00000120
load 00c 00050003  load 00d 00000040  load 00e 00000050  load 00f 00000130
load 010 00040004  load 011 00000040  load 012 00000050  load 013 00000140
# Operand A: 7, -10, max int, -3, 100
load 040 00000007  load 041 fffffff6  load 042 7fffffff  load 043 fffffffd
load 044 00000064
# Operand B: 3, 12, 1, -7, -50
load 050 00000003  load 051 0000000c  load 052 00000001  load 053 fffffff9
load 054 ffffffce
# Words under the NOP destination must survive
load 120 5a5a0120  load 121 5a5a0121  load 122 5a5a0122  load 123 5a5a0123
start 5
# ADD_RELU, wrap of max int plus one clamps to zero
expect 100 0000000a  expect 101 00000002  expect 102 00000000  expect 103 00000000
expect 104 00000032
expect 110 00000007  expect 111 0000000c  expect 112 7fffffff  expect 113 fffffffd
expect 120 5a5a0120  expect 121 5a5a0121  expect 122 5a5a0122  expect 123 5a5a0123
# AVG2 shifts the wrapped sum arithmetically
expect 130 00000005  expect 131 00000001  expect 132 c0000000  expect 133 fffffffb
expect 134 00000019
expect 140 00000007  expect 141 fffffff6  expect 142 7fffffff  expect 143 fffffffd

// File: logic/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module cmd_sequencer (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_op_en,
    input  wire [6:0]               i_cmd_count,
    output logic                    o_mem_req,
    output logic [`CNN_ADDR_W-1:0]  o_mem_addr,
    input  wire                     i_mem_ack,
    input  wire [31:0]              i_mem_rdata,
    output logic                    o_eng_req,
    output cnn_pkg::cnn_op_e        o_eng_op,
    output logic [15:0]             o_eng_count,
    output logic [`CNN_ADDR_W-1:0]  o_eng_a_addr,
    output logic [`CNN_ADDR_W-1:0]  o_eng_b_addr,
    output logic [`CNN_ADDR_W-1:0]  o_eng_dst_addr,
    input  wire                     i_eng_ack,
    output logic                    o_busy,
    output logic                    o_irq
);
    import cnn_pkg::*;

    localparam int AW      = `CNN_ADDR_W;
    localparam int BURST_W = $clog2(`CNN_CMD_WORDS);

    seq_state_e         state;
    logic [BURST_W-1:0] burst;
    logic [AW-1:0]      cmd_addr;
    logic [6:0]         done_cnt;
    logic               rd_start;
    logic               rd_done;
    logic               last_cmd;
    logic               skip_cmd;

    // New read only once the previous ack has dropped
    assign rd_start = (state == CMD_GET) && !o_mem_req && !i_mem_ack;
    assign rd_done  = (state == CMD_GET) && o_mem_req && i_mem_ack;

    assign last_cmd = (done_cnt + 7'd1 == i_cmd_count);

    // NOP or empty command never reaches the engine
    assign skip_cmd = (o_eng_op == NOP) || (o_eng_count == 16'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            burst     <= '0;
            cmd_addr  <= '0;
            done_cnt  <= '0;
            o_mem_req <= 1'b0;
            o_eng_req <= 1'b0;
            o_busy    <= 1'b0;
            o_irq     <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    cmd_addr <= AW'(`CNN_CMD_BASE);
                    done_cnt <= '0;
                    burst    <= '0;
                    if (i_op_en) begin
                        o_busy <= 1'b1;
                        state  <= (i_cmd_count == 7'd0) ? FINISH : CMD_GET;
                    end
                end
                CMD_GET: begin
                    if (rd_start) begin
                        o_mem_req <= 1'b1;
                    end else if (rd_done) begin
                        o_mem_req <= 1'b0;
                        burst     <= burst + 1'b1;
                        // Last word of the burst decoded
                        if (burst == BURST_W'(`CNN_CMD_WORDS - 1)) begin
                            state <= CMD_ISSUE;
                        end
                    end
                end
                CMD_ISSUE: begin
                    if (skip_cmd) begin
                        done_cnt <= done_cnt + 7'd1;
                        cmd_addr <= cmd_addr + AW'(`CNN_CMD_WORDS);
                        state    <= last_cmd ? FINISH : CMD_GET;
                    end else if (!i_eng_ack) begin
                        // Engine ack from the previous command is gone
                        o_eng_req <= 1'b1;
                        state     <= OP_RUN;
                    end
                end
                OP_RUN: begin
                    if (i_eng_ack) begin
                        o_eng_req <= 1'b0;
                        done_cnt  <= done_cnt + 7'd1;
                        cmd_addr  <= cmd_addr + AW'(`CNN_CMD_WORDS);
                        state     <= last_cmd ? FINISH : CMD_GET;
                    end
                end
                FINISH: begin
                    // Interrupt holds until reset
                    o_busy <= 1'b0;
                    o_irq  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command fields and read address
    always_ff @(posedge clk) begin
        if (rd_start) begin
            o_mem_addr <= cmd_addr + AW'(burst);
        end
        if (rd_done) begin
            case (burst)
                2'd0: begin
                    o_eng_op    <= cnn_op_e'(i_mem_rdata[2:0]);
                    o_eng_count <= i_mem_rdata[31:16];
                end
                2'd1: o_eng_a_addr   <= i_mem_rdata[AW-1:0];
                2'd2: o_eng_b_addr   <= i_mem_rdata[AW-1:0];
                default: o_eng_dst_addr <= i_mem_rdata[AW-1:0];
            endcase
        end
    end

    // Engine fields frozen across a held request
    assert property (@(posedge clk) disable iff (rst)
        o_eng_req |=> !o_eng_req ||
            $stable({o_eng_op, o_eng_count, o_eng_a_addr, o_eng_b_addr, o_eng_dst_addr}))
        else $error("engine fields changed while o_eng_req was high");

endmodule

`default_nettype wire

// File: logic/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Word address width of the shared memory
`define CNN_ADDR_W 10

// Words in the shared memory
`define CNN_MEM_DEPTH 1024

// Words per command burst
`define CNN_CMD_WORDS 4

// Word address of the first command
`define CNN_CMD_BASE 0

// Host, sequencer and engine
`define CNN_CLIENTS 3

`endif

// File: logic/cnn_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module cnn_core_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_op_en,
    input  wire [6:0]               i_cmd_count,
    input  wire                     i_host_req,
    input  wire                     i_host_we,
    input  wire [`CNN_ADDR_W-1:0]   i_host_addr,
    input  wire [31:0]              i_host_wdata,
    output wire                     o_host_ack,
    output wire [31:0]              o_host_rdata,
    output wire                     o_busy,
    output wire                     o_irq
);
    import cnn_pkg::*;

    // Arbiter client ports, indexed by client_e
    wire [`CNN_CLIENTS-1:0] arb_req;
    wire [`CNN_CLIENTS-1:0] arb_we;
    wire [`CNN_CLIENTS-1:0] arb_ack;
    wire [`CNN_ADDR_W-1:0]  arb_addr [`CNN_CLIENTS];
    wire [31:0]             arb_wdata [`CNN_CLIENTS];
    wire [31:0]             arb_rdata;

    // SRAM side
    wire                    mem_en;
    wire                    mem_we;
    wire [`CNN_ADDR_W-1:0]  mem_addr;
    wire [31:0]             mem_wdata;
    wire [31:0]             mem_rdata;

    // Sequencer to engine
    wire                    eng_req;
    wire                    eng_ack;
    wire cnn_op_e           eng_op;
    wire [15:0]             eng_count;
    wire [`CNN_ADDR_W-1:0]  eng_a_addr;
    wire [`CNN_ADDR_W-1:0]  eng_b_addr;
    wire [`CNN_ADDR_W-1:0]  eng_dst_addr;

    // Host port
    assign arb_req[HOST]   = i_host_req;
    assign arb_we[HOST]    = i_host_we;
    assign arb_addr[HOST]  = i_host_addr;
    assign arb_wdata[HOST] = i_host_wdata;
    assign o_host_ack      = arb_ack[HOST];
    assign o_host_rdata    = arb_rdata;

    // Sequencer only reads
    assign arb_we[SEQ]    = 1'b0;
    assign arb_wdata[SEQ] = '0;

    shared_sram u_sram (
        .i_clk   (clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .i_req       (arb_req),
        .i_we        (arb_we),
        .i_addr      (arb_addr),
        .i_wdata     (arb_wdata),
        .o_ack       (arb_ack),
        .o_rdata     (arb_rdata),
        .o_mem_en    (mem_en),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    cmd_sequencer u_seq (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_cmd_count    (i_cmd_count),
        .o_mem_req      (arb_req[SEQ]),
        .o_mem_addr     (arb_addr[SEQ]),
        .i_mem_ack      (arb_ack[SEQ]),
        .i_mem_rdata    (arb_rdata),
        .o_eng_req      (eng_req),
        .o_eng_op       (eng_op),
        .o_eng_count    (eng_count),
        .o_eng_a_addr   (eng_a_addr),
        .o_eng_b_addr   (eng_b_addr),
        .o_eng_dst_addr (eng_dst_addr),
        .i_eng_ack      (eng_ack),
        .o_busy         (o_busy),
        .o_irq          (o_irq)
    );

    vector_engine u_eng (
        .clk         (clk),
        .rst         (rst),
        .i_eng_req   (eng_req),
        .i_op        (eng_op),
        .i_count     (eng_count),
        .i_a_addr    (eng_a_addr),
        .i_b_addr    (eng_b_addr),
        .i_dst_addr  (eng_dst_addr),
        .o_eng_ack   (eng_ack),
        .o_mem_req   (arb_req[ENG]),
        .o_mem_we    (arb_we[ENG]),
        .o_mem_addr  (arb_addr[ENG]),
        .o_mem_wdata (arb_wdata[ENG]),
        .i_mem_ack   (arb_ack[ENG]),
        .i_mem_rdata (arb_rdata)
    );

endmodule

`default_nettype wire

// File: logic/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // Element-wise operations held in command word 0, bits 2:0
    typedef enum logic [2:0] {
        NOP      = 3'd0,
        ADD_RELU = 3'd1,
        MAX2     = 3'd2,
        AVG2     = 3'd3,
        COPY     = 3'd4
    } cnn_op_e;

    // Command sequencer FSM
    typedef enum logic [2:0] {
        IDLE,
        CMD_GET,
        CMD_ISSUE,
        OP_RUN,
        FINISH
    } seq_state_e;

    // Memory clients in arbiter port order
    typedef enum logic [1:0] {
        HOST = 2'd0,
        SEQ  = 2'd1,
        ENG  = 2'd2
    } client_e;

endpackage

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module mem_arbiter (
    input  wire                      clk,
    input  wire                      rst,
    input  wire [`CNN_CLIENTS-1:0]   i_req,
    input  wire [`CNN_CLIENTS-1:0]   i_we,
    input  wire [`CNN_ADDR_W-1:0]    i_addr [`CNN_CLIENTS],
    input  wire [31:0]               i_wdata [`CNN_CLIENTS],
    output logic [`CNN_CLIENTS-1:0]  o_ack,
    output logic [31:0]              o_rdata,
    output logic                     o_mem_en,
    output logic                     o_mem_we,
    output logic [`CNN_ADDR_W-1:0]   o_mem_addr,
    output logic [31:0]              o_mem_wdata,
    input  wire [31:0]               i_mem_rdata
);
    import cnn_pkg::*;

    // Idle, memory access, ack held, release before next grant
    enum logic [1:0] {A_IDLE, A_ACCESS, A_ACK, A_RELEASE} state;

    client_e gnt;
    client_e last;
    client_e pick;
    logic    pick_vld;

    // Round-robin search starting one past the last served client
    always_comb begin
        int idx;
        pick     = last;
        pick_vld = 1'b0;
        for (int i = 1; i <= `CNN_CLIENTS; i++) begin
            idx = (int'(last) + i) % `CNN_CLIENTS;
            if (!pick_vld && i_req[idx]) begin
                pick     = client_e'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= A_IDLE;
            gnt   <= HOST;
            // Host wins the first pick after reset
            last  <= ENG;
            o_ack <= '0;
        end else begin
            case (state)
                A_IDLE: begin
                    if (pick_vld) begin
                        gnt   <= pick;
                        state <= A_ACCESS;
                    end
                end
                A_ACCESS: begin
                    // SRAM samples this cycle, read data lines up with ack
                    o_ack[gnt] <= 1'b1;
                    state      <= A_ACK;
                end
                A_ACK: begin
                    // Hold ack until the client lets go of req
                    if (!i_req[gnt]) begin
                        o_ack[gnt] <= 1'b0;
                        state      <= A_RELEASE;
                    end
                end
                A_RELEASE: begin
                    last  <= gnt;
                    state <= A_IDLE;
                end
                default: state <= A_IDLE;
            endcase
        end
    end

    // Memory strobe only during the access cycle
    assign o_mem_en    = (state == A_ACCESS);
    assign o_mem_we    = i_we[gnt];
    assign o_mem_addr  = i_addr[gnt];
    assign o_mem_wdata = i_wdata[gnt];

    // Shared read bus, qualified by each client's ack
    assign o_rdata = i_mem_rdata;

    // Never more than one client acked
    assert property (@(posedge clk) disable iff (rst) $onehot0(o_ack))
        else $error("arbiter acked more than one client");

    // Ack only rises for a client that is requesting
    for (genvar c = 0; c < `CNN_CLIENTS; c++) begin : g_ack_chk
        assert property (@(posedge clk) disable iff (rst) $rose(o_ack[c]) |-> i_req[c])
            else $error("ack rose without req on client %0d", c);
    end

endmodule

`default_nettype wire

// File: logic/shared_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module shared_sram (
    input  wire                     i_clk,
    input  wire                     i_en,
    input  wire                     i_we,
    input  wire [`CNN_ADDR_W-1:0]   i_addr,
    input  wire [31:0]              i_wdata,
    output logic [31:0]             o_rdata
);

    // One 32-bit word per address
    logic [31:0] mem [`CNN_MEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end else begin
                // Read data appears one cycle after the enable
                o_rdata <= mem[i_addr];
            end
        end
        // Output keeps the last read word otherwise
    end

endmodule

`default_nettype wire

// File: logic/vector_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnn_cfg.svh"

module vector_engine (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_eng_req,
    input  wire cnn_pkg::cnn_op_e   i_op,
    input  wire [15:0]              i_count,
    input  wire [`CNN_ADDR_W-1:0]   i_a_addr,
    input  wire [`CNN_ADDR_W-1:0]   i_b_addr,
    input  wire [`CNN_ADDR_W-1:0]   i_dst_addr,
    output logic                    o_eng_ack,
    output logic                    o_mem_req,
    output logic                    o_mem_we,
    output logic [`CNN_ADDR_W-1:0]  o_mem_addr,
    output logic [31:0]             o_mem_wdata,
    input  wire                     i_mem_ack,
    input  wire [31:0]              i_mem_rdata
);
    import cnn_pkg::*;

    localparam int AW = `CNN_ADDR_W;

    enum logic [2:0] {E_IDLE, E_RD_A, E_RD_B, E_WR, E_DONE} state;

    logic [15:0]        idx;
    logic signed [31:0] a_val;
    logic signed [31:0] b_val;
    logic signed [31:0] sum;
    logic signed [31:0] result;
    logic               acc_start;
    logic               acc_done;
    logic               last_elem;

    // One access in flight, next one waits for the old ack to fall
    assign acc_start = (state inside {E_RD_A, E_RD_B, E_WR}) && !o_mem_req && !i_mem_ack;
    assign acc_done  = o_mem_req && i_mem_ack;
    assign last_elem = (idx == i_count - 16'd1);

    // Wraps at 32 bits
    assign sum = a_val + b_val;

    always_comb begin
        case (i_op)
            // Clamp after the wrap
            ADD_RELU: result = sum[31] ? 32'sd0 : sum;
            MAX2:     result = (a_val > b_val) ? a_val : b_val;
            AVG2:     result = sum >>> 1;
            default:  result = a_val;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= E_IDLE;
            idx       <= '0;
            o_eng_ack <= 1'b0;
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
        end else begin
            if (acc_done) begin
                o_mem_req <= 1'b0;
            end else if (acc_start) begin
                o_mem_req <= 1'b1;
                o_mem_we  <= (state == E_WR);
            end
            case (state)
                E_IDLE: begin
                    idx <= '0;
                    if (i_eng_req) begin
                        state <= E_RD_A;
                    end
                end
                E_RD_A: begin
                    // COPY needs no second operand
                    if (acc_done) begin
                        state <= (i_op == COPY) ? E_WR : E_RD_B;
                    end
                end
                E_RD_B: begin
                    if (acc_done) begin
                        state <= E_WR;
                    end
                end
                E_WR: begin
                    if (acc_done && last_elem) begin
                        o_eng_ack <= 1'b1;
                        state     <= E_DONE;
                    end else if (acc_done) begin
                        idx   <= idx + 16'd1;
                        state <= E_RD_A;
                    end
                end
                E_DONE: begin
                    // Release once the sequencer drops its request
                    if (!i_eng_req) begin
                        o_eng_ack <= 1'b0;
                        state     <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // Addresses, write data and operand capture
    always_ff @(posedge clk) begin
        if (acc_start) begin
            case (state)
                E_RD_A: o_mem_addr <= i_a_addr + AW'(idx);
                E_RD_B: o_mem_addr <= i_b_addr + AW'(idx);
                default: begin
                    o_mem_addr  <= i_dst_addr + AW'(idx);
                    o_mem_wdata <= result;
                end
            endcase
        end
        if (acc_done && state == E_RD_A) begin
            a_val <= i_mem_rdata;
        end
        if (acc_done && state == E_RD_B) begin
            b_val <= i_mem_rdata;
        end
    end

    // Request held until the arbiter acks it
    assert property (@(posedge clk) disable iff (rst) $fell(o_mem_req) |-> $past(i_mem_ack))
        else $error("engine dropped o_mem_req before ack");

endmodule

`default_nettype wire
